/* hdl/eeprom_bit_engine.sv */
`timescale 1ns/1ps

module eeprom_bit_engine #(
    parameter int CLK_DIV = 2
) (
    input  logic CLK,
    input  logic RESET,
    input  logic sda_in,
    output logic scl,
    output logic sda_out,
    output logic sda_oe,
    serial_bus_if.engine bus
);
    import eeprom_pkg::*;

    // one bit = CLK_DIV cycles SCL low, then CLK_DIV cycles SCL high
    localparam int PH_W = $clog2(2 * CLK_DIV);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(2 * CLK_DIV - 1);
    localparam logic [PH_W-1:0] PH_HIGH = PH_W'(CLK_DIV);
    localparam logic [PH_W-1:0] PH_DATA = PH_W'(CLK_DIV / 2);  // mid low phase

    typedef enum logic [1:0] {E_IDLE, E_LOAD, E_RUN} eng_state_t;

    eng_state_t      state;
    bus_op_t         op_r;
    logic [7:0]      tx_r;
    logic [7:0]      rx_sh;
    logic            mack_r;
    logic [PH_W-1:0] ph;
    logic [PH_W-1:0] ph_nxt;
    logic [PH_W-1:0] tgt_ph;
    logic [3:0]      bit_cnt;
    logic [3:0]      bit_nxt;
    logic [3:0]      tgt_bit;
    logic [3:0]      last_bit;
    logic            last_ph;
    logic            is_cond;
    logic            op_end;
    logic            scl_tgt;
    logic            sda_upd;
    logic            oe_tgt;

    always_comb
    begin
        last_ph  = (ph == PH_LAST);
        ph_nxt   = last_ph ? '0 : ph + 1'b1;
        bit_nxt  = last_ph ? bit_cnt + 4'd1 : bit_cnt;
        is_cond  = (op_r == OP_START) || (op_r == OP_STOP);
        last_bit = is_cond ? 4'd1 : 4'd8;
        op_end   = (state == E_RUN) && last_ph && (bit_cnt == last_bit);

        // position the outputs move to on this edge
        if (state == E_LOAD)
        begin
            tgt_bit = '0;
            tgt_ph  = '0;
        end
        else
        begin
            tgt_bit = bit_nxt;
            tgt_ph  = ph_nxt;
        end

        // second bit of start/stop keeps SCL high and moves SDA at its start
        scl_tgt = (is_cond && tgt_bit == 4'd1) || (tgt_ph >= PH_HIGH);
        sda_upd = (is_cond && tgt_bit == 4'd1) ? (tgt_ph == '0) : (tgt_ph == PH_DATA);

        case (op_r)
            OP_START: oe_tgt = (tgt_bit == 4'd1);   // release, then fall
            OP_STOP:  oe_tgt = (tgt_bit == 4'd0);   // pull low, then rise
            OP_WRITE: oe_tgt = (tgt_bit == 4'd8) ? 1'b0 : ~tx_r[3'd7 - tgt_bit[2:0]];
            default:  oe_tgt = (tgt_bit == 4'd8) ? mack_r : 1'b0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= E_IDLE;
            ph           <= '0;
            bit_cnt      <= '0;
            scl          <= 1'b1;
            sda_oe       <= 1'b0;
            bus.ack_done <= 1'b0;
            bus.ack_seen <= 1'b0;
        end
        else
        begin
            bus.ack_done <= 1'b0;
            case (state)
                E_IDLE:
                    if (bus.go)
                        state <= E_LOAD;
                E_LOAD:
                begin
                    state   <= E_RUN;
                    ph      <= '0;
                    bit_cnt <= '0;
                end
                default:
                    if (op_end)
                    begin
                        state        <= E_IDLE;
                        bus.ack_done <= 1'b1;
                    end
                    else
                    begin
                        ph      <= ph_nxt;
                        bit_cnt <= bit_nxt;
                    end
            endcase

            // bus lines hold between operations
            if (state == E_LOAD || (state == E_RUN && !op_end))
            begin
                scl <= scl_tgt;
                if (sda_upd)
                    sda_oe <= oe_tgt;
            end

            if (state == E_RUN && last_ph && !is_cond && bit_cnt == 4'd8)
                bus.ack_seen <= ~sda_in;   // low on SDA = ack
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == E_IDLE && bus.go)
        begin
            op_r   <= bus.op;
            tx_r   <= bus.tx_byte;
            mack_r <= bus.master_ack;
        end
        // sampled at the end of the SCL high phase
        if (state == E_RUN && last_ph && !is_cond && bit_cnt < 4'd8)
            rx_sh <= {rx_sh[6:0], sda_in};
    end

    assign bus.rx_byte = rx_sh;
    assign sda_out     = 1'b0;   // open drain, only ever pulls low

endmodule

/* hdl/eeprom_cmd_regs.sv */
`timescale 1ns/1ps

module eeprom_cmd_regs (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            cmd_valid,
    input  logic                            cmd_read,
    input  logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [7:0]                      cmd_wdata,
    input  logic                            finish,
    input  logic [7:0]                      rx_data,
    input  logic                            nack,
    output logic                            start,
    output eeprom_pkg::ee_cmd_t             cmd,
    output logic                            busy,
    output logic                            done,
    output logic [7:0]                      rd_data,
    output logic                            nack_err
);

    logic accept;

    assign accept = cmd_valid && !busy;   // strobes while busy are lost

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy     <= 1'b0;
            start    <= 1'b0;
            done     <= 1'b0;
            nack_err <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            done  <= 1'b0;
            if (accept)
            begin
                busy  <= 1'b1;
                start <= 1'b1;
            end
            else if (finish)
            begin
                busy     <= 1'b0;
                done     <= 1'b1;
                nack_err <= nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
            cmd <= '{rd: cmd_read, addr: cmd_addr, wdata: cmd_wdata};
        if (finish)
            rd_data <= rx_data;   // held until next done
    end

endmodule

/* hdl/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 2
) (
    input  logic                            CLK,
    input  logic                            RESET,
    input  logic                            cmd_valid,
    input  logic                            cmd_read,
    input  logic [eeprom_pkg::ADDR_W-1:0]   cmd_addr,
    input  logic [7:0]                      cmd_wdata,
    output logic                            busy,
    output logic                            done,
    output logic [7:0]                      rd_data,
    output logic                            nack_err,
    output logic                            scl,
    output logic                            sda_out,
    output logic                            sda_oe,
    input  logic                            sda_in
);
    import eeprom_pkg::*;

    ee_cmd_t    cmd;
    logic       start;
    logic       finish;
    logic [7:0] rx_data;
    logic       nack;

    serial_bus_if bus_i ();

    eeprom_cmd_regs cmd_regs_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .finish    (finish),
        .rx_data   (rx_data),
        .nack      (nack),
        .start     (start),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .nack_err  (nack_err)
    );

    eeprom_sequencer sequencer_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .start   (start),
        .cmd     (cmd),
        .finish  (finish),
        .rx_data (rx_data),
        .nack    (nack),
        .bus     (bus_i.sequencer)
    );

    eeprom_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) bit_engine_i (
        .CLK     (CLK),
        .RESET   (RESET),
        .sda_in  (sda_in),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_oe  (sda_oe),
        .bus     (bus_i.engine)
    );

endmodule

/* hdl/eeprom_pkg.sv */
package eeprom_pkg;

    // 2048 byte part, top three bits travel in the control byte
    localparam int ADDR_W = 11;

    // device type nibble of the control byte
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    // one operation of the bit engine
    typedef enum logic [1:0]
    {
        OP_START,
        OP_STOP,
        OP_WRITE,   // 8 bits out, ack slot sampled
        OP_READ     // 8 bits in, master ack slot driven
    } bus_op_t;

    // host command as held for the sequencer
    typedef struct packed
    {
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } ee_cmd_t;

endpackage

/* hdl/eeprom_sequencer.sv */
`timescale 1ns/1ps

module eeprom_sequencer (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 start,
    input  eeprom_pkg::ee_cmd_t  cmd,
    output logic                 finish,
    output logic [7:0]           rx_data,
    output logic                 nack,
    serial_bus_if.sequencer      bus
);
    import eeprom_pkg::*;

    typedef enum logic [3:0]
    {
        ST_IDLE,
        ST_START,
        ST_CTRL_W,
        ST_ADDR,
        ST_DATA,
        ST_RSTART,
        ST_CTRL_R,
        ST_READ,
        ST_STOP
    } step_t;

    step_t      step;
    step_t      step_nxt;
    bus_op_t    op_nxt;
    logic [7:0] tx_nxt;
    logic       advance;
    logic       wr_step;

    always_comb
    begin
        advance = (step == ST_IDLE) ? start : bus.ack_done;
        wr_step = (step == ST_CTRL_W) || (step == ST_ADDR) ||
                  (step == ST_DATA) || (step == ST_CTRL_R);

        case (step)
            ST_IDLE:   step_nxt = ST_START;
            ST_START:  step_nxt = ST_CTRL_W;
            ST_CTRL_W: step_nxt = bus.ack_seen ? ST_ADDR : ST_STOP;
            ST_ADDR:
                if (!bus.ack_seen)
                    step_nxt = ST_STOP;
                else if (cmd.rd)
                    step_nxt = ST_RSTART;
                else
                    step_nxt = ST_DATA;
            ST_DATA:   step_nxt = ST_STOP;
            ST_RSTART: step_nxt = ST_CTRL_R;
            ST_CTRL_R: step_nxt = bus.ack_seen ? ST_READ : ST_STOP;
            ST_READ:   step_nxt = ST_STOP;
            default:   step_nxt = ST_IDLE;
        endcase

        case (step_nxt)
            ST_START,
            ST_RSTART: op_nxt = OP_START;
            ST_READ:   op_nxt = OP_READ;
            ST_STOP:   op_nxt = OP_STOP;
            default:   op_nxt = OP_WRITE;
        endcase

        // control byte: type nibble, block bits a10..a8, r/w
        case (step_nxt)
            ST_CTRL_W: tx_nxt = {DEV_TYPE, cmd.addr[ADDR_W-1:8], 1'b0};
            ST_ADDR:   tx_nxt = cmd.addr[7:0];
            ST_DATA:   tx_nxt = cmd.wdata;
            ST_CTRL_R: tx_nxt = {DEV_TYPE, cmd.addr[ADDR_W-1:8], 1'b1};
            default:   tx_nxt = 8'h00;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            step   <= ST_IDLE;
            bus.go <= 1'b0;
            finish <= 1'b0;
            nack   <= 1'b0;
        end
        else
        begin
            bus.go <= 1'b0;
            finish <= 1'b0;
            if (advance)
            begin
                step   <= step_nxt;
                bus.go <= (step_nxt != ST_IDLE);
                finish <= (step == ST_STOP);
                if (step == ST_IDLE)
                    nack <= 1'b0;
                else if (wr_step && !bus.ack_seen)
                    nack <= 1'b1;   // machine already heads for stop
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            bus.op      <= op_nxt;
            bus.tx_byte <= tx_nxt;
        end
        if (advance && step == ST_READ)
            rx_data <= bus.rx_byte;
    end

    // single byte read always closes with a master nack
    assign bus.master_ack = 1'b0;

endmodule

/* hdl/serial_bus_if.sv */
`timescale 1ns/1ps

interface serial_bus_if;
    import eeprom_pkg::*;

    logic       go;          // one cycle, only when engine is free
    bus_op_t    op;
    logic [7:0] tx_byte;
    logic       master_ack;  // 1 = ack the read byte, 0 = nack

    logic       ack_done;    // one pulse per go
    logic [7:0] rx_byte;
    logic       ack_seen;    // device pulled SDA low in the ack slot

    modport sequencer
    (
        output go, op, tx_byte, master_ack,
        input  ack_done, rx_byte, ack_seen
    );

    modport engine
    (
        input  go, op, tx_byte, master_ack,
        output ack_done, rx_byte, ack_seen
    );

endinterface

/* tb/eeprom_ctrl_tb.sv */
`timescale 1ns/1ps

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int CLK_DIV   = 2;
    localparam int N_TXN     = 59;   // 58 transfers plus the idle watch of test 4
    localparam int CYC_LIMIT = N_TXN * 42 * (2 * CLK_DIV) * 2;

    logic              CLK;
    logic              RESET;
    logic              cmd_valid;
    logic              cmd_read;
    logic [ADDR_W-1:0] cmd_addr;
    logic [7:0]        cmd_wdata;
    logic              busy;
    logic              done;
    logic [7:0]        rd_data;
    logic              nack_err;
    logic              scl;
    logic              sda_out;
    logic              sda_oe;
    tri1               sda_line;   // open drain with pull-up
    logic              no_ack;
    int                start_cnt;
    int                stop_cnt;
    int                bad_cond_cnt;

    logic [7:0]        sb [0:2047];
    logic [7:0]        exp_data;
    logic              exp_nack;
    logic              chk_read;
    logic              cmd_seen;
    logic [ADDR_W-1:0] addr_x;
    logic [ADDR_W-1:0] addr_y;
    logic [31:0]       rnd;
    integer            seed;
    int                exp_starts;
    int                exp_stops;
    int                issued;
    int                done_cnt;
    int                err_cnt;
    int                fail_tests;
    int                cycles;
    int                errs;
    int                n;

    assign sda_line = sda_oe ? sda_out : 1'bz;

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) dut_i (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_read  (cmd_read),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .busy      (busy),
        .done      (done),
        .rd_data   (rd_data),
        .nack_err  (nack_err),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .sda_in    (sda_line)
    );

    eeprom_model model_i (
        .scl          (scl),
        .sda          (sda_line),
        .no_ack       (no_ack),
        .start_cnt    (start_cnt),
        .stop_cnt     (stop_cnt),
        .bad_cond_cnt (bad_cond_cnt)
    );

    always #20 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > CYC_LIMIT)
        begin
            $display("timeout after %0d cycles, a transfer never finished", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    always @(posedge CLK)
        if (done)
            done_cnt <= done_cnt + 1;

    idle_a: assert property (@(posedge CLK)
        (!RESET && !cmd_seen) |-> (scl && !sda_oe && !busy && !done))
        else
        begin
            $display("ERR %0t idle outputs scl/sda_oe/busy/done expected 1000 got %b%b%b%b",
                     $time, $sampled(scl), $sampled(sda_oe), $sampled(busy), $sampled(done));
            err_cnt++;
        end

    busy_a: assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && !busy) |=> busy)
        else
        begin
            $display("ERR %0t busy expected 1 got %b", $time, $sampled(busy));
            err_cnt++;
        end

    sda_out_a: assert property (@(posedge CLK) disable iff (RESET) sda_oe |-> !sda_out)
        else
        begin
            $display("ERR %0t sda_out expected 0 got %b", $time, $sampled(sda_out));
            err_cnt++;
        end

    rd_data_a: assert property (@(posedge CLK) (done && chk_read) |-> (rd_data == exp_data))
        else
        begin
            $display("ERR %0t rd_data expected %h got %h",
                     $time, $sampled(exp_data), $sampled(rd_data));
            err_cnt++;
        end

    nack_a: assert property (@(posedge CLK) done |-> (nack_err == exp_nack))
        else
        begin
            $display("ERR %0t nack_err expected %b got %b",
                     $time, $sampled(exp_nack), $sampled(nack_err));
            err_cnt++;
        end

    one_done_a: assert property (@(posedge CLK) done |-> (done_cnt < issued))
        else
        begin
            $display("done pulse at %0t without an accepted command behind it", $time);
            err_cnt++;
        end

    starts_a: assert property (@(posedge CLK) done |-> (start_cnt == exp_starts))
        else
        begin
            $display("ERR %0t start_cnt expected %0d got %0d",
                     $time, $sampled(exp_starts), $sampled(start_cnt));
            err_cnt++;
        end

    stops_a: assert property (@(posedge CLK) done |-> (stop_cnt == exp_stops))
        else
        begin
            $display("ERR %0t stop_cnt expected %0d got %0d",
                     $time, $sampled(exp_stops), $sampled(stop_cnt));
            err_cnt++;
        end

    cond_a: assert property (@(posedge CLK) disable iff (RESET)
        bad_cond_cnt == $past(bad_cond_cnt))
        else
        begin
            $display("sda moved while scl was high in the middle of a byte at %0t", $time);
            err_cnt++;
        end

    task automatic expect_cmd(input logic rd, input logic [ADDR_W-1:0] addr,
                              input logic [7:0] data);
        chk_read   = rd;
        exp_nack   = no_ack;
        exp_starts = exp_starts + (rd ? 2 : 1);
        exp_stops  = exp_stops + 1;
        issued     = issued + 1;
        if (rd)
            exp_data = sb[addr];
        else if (!no_ack)
            sb[addr] = data;
    endtask

    task automatic drive_cmd(input logic rd, input logic [ADDR_W-1:0] addr,
                             input logic [7:0] data);
        @(negedge CLK);
        cmd_valid = 1'b1;
        cmd_read  = rd;
        cmd_addr  = addr;
        cmd_wdata = data;
        cmd_seen  = 1'b1;
        @(negedge CLK);
        cmd_valid = 1'b0;
    endtask

    // returns once the checks on done have run
    task automatic wait_done();
        do
            @(negedge CLK);
        while (!done);
        @(negedge CLK);
    endtask

    task automatic transfer(input logic rd, input logic [ADDR_W-1:0] addr,
                            input logic [7:0] data);
        expect_cmd(rd, addr, data);
        drive_cmd(rd, addr, data);
        wait_done();
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: failed, %0d errors", name, err_cnt - errs_before);
            fail_tests++;
        end
    endtask

    initial
    begin
        seed       = 32'he360;
        CLK        = 1'b0;
        RESET      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_read   = 1'b0;
        cmd_addr   = '0;
        cmd_wdata  = '0;
        no_ack     = 1'b0;
        cmd_seen   = 1'b0;
        chk_read   = 1'b0;
        exp_data   = '0;
        exp_nack   = 1'b0;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;

        errs = err_cnt;
        repeat (10) @(negedge CLK);   // idle stretch before first command
        transfer(1'b0, 11'h123, 8'ha5);
        report_test("1 reset state and first command", errs);

        errs = err_cnt;
        for (n = 0; n < 16; n++)
        begin
            rnd = $random(seed);
            transfer(1'b0, rnd[10:0], rnd[18:11]);
            transfer(1'b1, rnd[10:0], 8'h00);
        end
        report_test("2 write then read round trip", errs);

        errs = err_cnt;
        rnd  = $random(seed);
        for (n = 0; n < 8; n++)
            transfer(1'b0, {n[2:0], rnd[7:0]}, {n[2:0], rnd[12:8]});
        for (n = 0; n < 8; n++)
            transfer(1'b1, {n[2:0], rnd[7:0]}, 8'h00);
        report_test("3 block bits in control byte", errs);

        errs   = err_cnt;
        rnd    = $random(seed);
        addr_x = rnd[10:0];
        addr_y = addr_x ^ 11'h2a5;
        transfer(1'b0, addr_y, rnd[18:11]);
        expect_cmd(1'b0, addr_x, rnd[26:19]);
        drive_cmd(1'b0, addr_x, rnd[26:19]);
        repeat (3) @(negedge CLK);
        drive_cmd(1'b0, addr_y, ~rnd[18:11]);   // lands while busy
        wait_done();
        repeat (42 * 2 * CLK_DIV) @(negedge CLK);   // room for a stray second done
        transfer(1'b1, addr_x, 8'h00);
        transfer(1'b1, addr_y, 8'h00);
        report_test("4 strobe while busy dropped", errs);

        errs = err_cnt;
        rnd  = $random(seed);
        transfer(1'b0, rnd[10:0], rnd[18:11]);
        @(negedge CLK);
        no_ack = 1'b1;
        transfer(1'b0, rnd[10:0], ~rnd[18:11]);
        @(negedge CLK);
        no_ack = 1'b0;
        transfer(1'b1, rnd[10:0], 8'h00);
        report_test("5 nack on write", errs);

        errs = err_cnt;
        rnd  = $random(seed);
        transfer(1'b0, rnd[10:0], rnd[18:11]);
        transfer(1'b1, rnd[10:0], 8'h00);
        report_test("6 bus protocol", errs);

        $display("6 tests, %0d failed, %0d check errors, %0d transfers",
                 fail_tests, err_cnt, issued);
        if (fail_tests == 0 && err_cnt == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* tb/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model (
    input  logic scl,
    inout  wire  sda,
    input  logic no_ack,          // 1 = never acknowledge
    output int   start_cnt,
    output int   stop_cnt,
    output int   bad_cond_cnt     // start or stop inside a byte
);
    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum int {M_IDLE, M_CTRL, M_ADDR, M_DATA, M_SEND} mstate_t;

    logic [7:0] mem [0:2047];
    mstate_t    mstate;
    logic [7:0] shreg;
    logic [7:0] out_byte;
    logic [2:0] blk;
    logic [7:0] addr_lo;
    logic       rd_req;
    logic       pull_low;
    logic       sda_prev;
    int         bit_cnt;

    assign sda = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i * 157) ^ 8'(i >> 3);
        mstate       = M_IDLE;
        bit_cnt      = 0;
        pull_low     = 1'b0;
        rd_req       = 1'b0;
        blk          = '0;
        addr_lo      = '0;
        start_cnt    = 0;
        stop_cnt     = 0;
        bad_cond_cnt = 0;
    end

    // sda moving while scl is high
    always @(sda)
    begin
        // a repeated start comes after one clock of its own setup bit
        if (scl === 1'b1 && sda_prev === 1'b1 && sda === 1'b0)
        begin
            if (mstate != M_IDLE && bit_cnt > 1)
                bad_cond_cnt++;
            start_cnt++;
            mstate  = M_CTRL;
            bit_cnt = 0;
        end
        else if (scl === 1'b1 && sda_prev === 1'b0 && sda === 1'b1)
        begin
            if (mstate != M_IDLE && bit_cnt > 1)
                bad_cond_cnt++;
            stop_cnt++;
            mstate   = M_IDLE;
            bit_cnt  = 0;
            pull_low = 1'b0;
        end
        sda_prev = sda;
    end

    always @(posedge scl)
    begin
        if (mstate == M_SEND)
            bit_cnt++;   // host samples, ninth is its ack
        else if (mstate != M_IDLE)
        begin
            if (bit_cnt < 8)
                shreg = {shreg[6:0], sda};
            bit_cnt++;
        end
    end

    always @(negedge scl)
    begin
        case (mstate)
            M_IDLE:
                pull_low = 1'b0;
            M_SEND:
                if (bit_cnt < 8)
                    pull_low = ~out_byte[7 - bit_cnt];
                else if (bit_cnt == 8)
                    pull_low = 1'b0;   // host ack slot
                else
                begin
                    pull_low = 1'b0;
                    mstate   = M_IDLE;
                    bit_cnt  = 0;
                end
            default:
                if (bit_cnt == 8)
                begin
                    if (no_ack || (mstate == M_CTRL && shreg[7:4] != DEV_CODE))
                    begin
                        mstate  = M_IDLE;   // wait for stop
                        bit_cnt = 0;
                    end
                    else
                    begin
                        pull_low = 1'b1;
                        case (mstate)
                            M_CTRL:
                            begin
                                blk    = shreg[3:1];
                                rd_req = shreg[0];
                            end
                            M_ADDR:  addr_lo = shreg;
                            default: mem[{blk, addr_lo}] = shreg;
                        endcase
                    end
                end
                else if (bit_cnt == 9)
                begin
                    pull_low = 1'b0;
                    bit_cnt  = 0;
                    case (mstate)
                        M_CTRL:
                            if (rd_req)
                            begin
                                mstate   = M_SEND;
                                out_byte = mem[{blk, addr_lo}];
                                pull_low = ~out_byte[7];   // first bit right away
                            end
                            else
                                mstate = M_ADDR;
                        M_ADDR:  mstate = M_DATA;
                        default: mstate = M_IDLE;
                    endcase
                end
        endcase
    end

endmodule

/* verilog.f */
hdl/eeprom_pkg.sv
hdl/serial_bus_if.sv
hdl/eeprom_bit_engine.sv
hdl/eeprom_sequencer.sv
hdl/eeprom_cmd_regs.sv
hdl/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/eeprom_ctrl_tb.sv
